// ==== hdl/isa_pkg.sv ====
package isa_pkg;

    localparam int XLEN = 32;
    localparam int BYTE_OFS = 2;   // Byte offset bits in a word address

    typedef logic [XLEN-1:0] word_t;
    typedef logic [XLEN-1:0] addr_t;

    // funct3 encoding of the access size for loads and stores
    typedef enum logic [2:0] {
        size_byte = 3'b000,
        size_half = 3'b001,
        size_word = 3'b010
    } mem_size_t;

endpackage

// ==== hdl/ooo_pkg.sv ====
package ooo_pkg;

    localparam int TAG_W = 32;
    localparam int PHY_W = 8;
    localparam int LANES = 4;   // Bytes per data word

    // Program order tag, larger is younger
    typedef logic [TAG_W-1:0] inst_num_t;

    typedef logic [PHY_W-1:0] phy_reg_t;

    // Bit n set means byte n of the word is valid
    typedef logic [LANES-1:0] cov_t;

endpackage

// ==== hdl/store_buffer.sv ====
module store_buffer
    import isa_pkg::*, ooo_pkg::*;
#(
    parameter int SB_DEPTH = 8
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      exception,
    input  logic      mret_sig,
    input  logic      memwrite,
    input  logic      memread,
    input  mem_size_t funct3,
    input  addr_t     mem_addr,
    input  word_t     mem_data,
    input  inst_num_t inst_num,
    input  phy_reg_t  load_phy,
    input  logic      commit,
    input  addr_t     commit_addr,
    input  inst_num_t commit_inst_num,
    output word_t     fwd_data,
    output cov_t      fwd_mask,
    output mem_size_t load_size,
    output phy_reg_t  load_phy_out,
    output inst_num_t inst_num_out,
    output logic      load_done,
    output logic      order_violation,
    output logic      sb_full,
    output logic      drain_we,
    output addr_t     drain_addr,
    output word_t     drain_data,
    output cov_t      drain_mask
);
    localparam int IDX_W = (SB_DEPTH > 1) ? $clog2(SB_DEPTH) : 1;

    logic [SB_DEPTH-1:0] valid;
    inst_num_t           ent_tag  [SB_DEPTH];
    addr_t               ent_addr [SB_DEPTH];
    word_t               ent_data [SB_DEPTH];
    cov_t                ent_cov  [SB_DEPTH];

    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] commit_idx;
    logic [IDX_W-1:0] old_idx;
    logic [IDX_W-1:0] fwd_idx;
    logic             any_free;
    logic             commit_hit;
    logic             old_hit;
    logic             fwd_hit;
    inst_num_t        fwd_tag;
    cov_t             fwd_cov;
    cov_t             st_cov;
    word_t            st_data;
    word_t            new_data;
    cov_t             new_cov;
    logic             alloc;

    function automatic cov_t size_cov(input mem_size_t size);
        case (size)
            size_byte: return 4'b0001;
            size_half: return 4'b0011;
            default:   return 4'b1111;
        endcase
    endfunction

    function automatic word_t lane_bits(input cov_t cov);
        word_t bits;
        for (int n = 0; n < LANES; n++) begin
            bits[8*n +: 8] = {8{cov[n]}};
        end
        return bits;
    endfunction

    // Lowest free slot wins
    always_comb begin
        any_free = 1'b0;
        free_idx = '0;
        for (int i = SB_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                any_free = 1'b1;
                free_idx = IDX_W'(i);
            end
        end
    end

    assign sb_full = ~any_free;
    assign alloc   = memwrite && any_free;

    always_comb begin
        commit_hit = 1'b0;
        commit_idx = '0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (valid[i] && ent_addr[i] == commit_addr && ent_tag[i] == commit_inst_num) begin
                commit_hit = 1'b1;
                commit_idx = IDX_W'(i);
            end
        end
    end

    assign drain_we   = commit && commit_hit;
    assign drain_addr = ent_addr[commit_idx];
    assign drain_data = ent_data[commit_idx];
    assign drain_mask = ent_cov[commit_idx];

    // Older same-address entry to merge into the new store
    always_comb begin
        old_hit = 1'b0;
        old_idx = '0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (valid[i] && ent_addr[i] == mem_addr && ent_tag[i] < inst_num &&
                !(drain_we && commit_idx == IDX_W'(i))) begin
                old_hit = 1'b1;
                old_idx = IDX_W'(i);
            end
        end
    end

    assign st_cov   = size_cov(funct3);
    assign st_data  = mem_data & lane_bits(st_cov);   // Low-justified store bytes
    assign new_data = old_hit ? (st_data | (ent_data[old_idx] & ~lane_bits(st_cov))) : st_data;
    assign new_cov  = old_hit ? (st_cov | ent_cov[old_idx]) : st_cov;

    // Newest matching entry for the load
    always_comb begin
        fwd_hit = 1'b0;
        fwd_idx = '0;
        fwd_tag = '0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (valid[i] && ent_addr[i] == mem_addr && (!fwd_hit || ent_tag[i] > fwd_tag)) begin
                fwd_hit = 1'b1;
                fwd_idx = IDX_W'(i);
                fwd_tag = ent_tag[i];
            end
        end
    end

    assign fwd_cov = fwd_hit ? (ent_cov[fwd_idx] & size_cov(funct3)) : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (exception || mret_sig) begin
            valid <= '0;
        end else begin
            if (drain_we) valid[commit_idx] <= 1'b0;
            if (memwrite && old_hit) valid[old_idx] <= 1'b0;
            if (alloc) valid[free_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            ent_tag[free_idx]  <= inst_num;
            ent_addr[free_idx] <= mem_addr;
            ent_data[free_idx] <= new_data;
            ent_cov[free_idx]  <= new_cov;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_done       <= 1'b0;
            order_violation <= 1'b0;
        end else begin
            load_done       <= memread;
            order_violation <= memread && fwd_hit && fwd_tag > inst_num;   // Store younger than load
        end
    end

    always_ff @(posedge clk) begin
        if (memread) begin
            fwd_data     <= ent_data[fwd_idx] & lane_bits(fwd_cov);
            fwd_mask     <= fwd_cov;
            load_size    <= funct3;
            load_phy_out <= load_phy;
            inst_num_out <= inst_num;
        end
    end

endmodule

// ==== hdl/data_mem.sv ====
module data_mem
    import isa_pkg::*, ooo_pkg::*;
#(
    parameter int MEM_WORDS = 64
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  we,
    input  addr_t waddr,
    input  word_t wdata,
    input  cov_t  wmask,
    input  addr_t raddr,
    output word_t rdata
);
    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    word_t            mem [MEM_WORDS];
    logic [IDX_W-1:0] widx;
    logic [IDX_W-1:0] ridx;

    assign widx = waddr[BYTE_OFS +: IDX_W];   // Word index above byte offset
    assign ridx = raddr[BYTE_OFS +: IDX_W];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            for (int n = 0; n < LANES; n++) begin
                if (wmask[n]) mem[widx][8*n +: 8] <= wdata[8*n +: 8];
            end
        end
    end

    // Read sees the word before a same-edge write
    always_ff @(posedge clk) begin
        rdata <= mem[ridx];
    end

endmodule

// ==== hdl/load_merge.sv ====
module load_merge
    import isa_pkg::*, ooo_pkg::*;
(
    input  word_t     fwd_data,
    input  cov_t      fwd_mask,
    input  word_t     mem_word,
    input  mem_size_t load_size,
    output word_t     load_data
);
    word_t merged;

    // Forwarded byte overrides memory byte per lane
    always_comb begin
        for (int n = 0; n < LANES; n++) begin
            if (fwd_mask[n]) begin
                merged[8*n +: 8] = fwd_data[8*n +: 8];
            end else begin
                merged[8*n +: 8] = mem_word[8*n +: 8];
            end
        end
    end

    always_comb begin
        case (load_size)
            size_byte: load_data = {{24{merged[7]}}, merged[7:0]};     // LB
            size_half: load_data = {{16{merged[15]}}, merged[15:0]};   // LH
            size_word: load_data = merged;
            default:   load_data = merged;
        endcase
    end

endmodule

// ==== hdl/lsu_top.sv ====
module lsu_top
    import isa_pkg::*, ooo_pkg::*;
#(
    parameter int SB_DEPTH  = 8,
    parameter int MEM_WORDS = 64
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      exception,
    input  logic      mret_sig,
    input  logic      memwrite,
    input  logic      memread,
    input  mem_size_t funct3,
    input  addr_t     mem_addr,
    input  word_t     mem_data,
    input  inst_num_t inst_num,
    input  phy_reg_t  load_phy,
    input  logic      commit,
    input  addr_t     commit_addr,
    input  inst_num_t commit_inst_num,
    output word_t     load_data,
    output cov_t      load_fwd_mask,
    output phy_reg_t  load_phy_out,
    output inst_num_t inst_num_out,
    output logic      load_done,
    output logic      order_violation,
    output logic      sb_full
);
    word_t     fwd_data;
    mem_size_t load_size;
    logic      drain_we;
    addr_t     drain_addr;
    word_t     drain_data;
    cov_t      drain_mask;
    word_t     mem_word;

    store_buffer #(
        .SB_DEPTH(SB_DEPTH)
    ) store_buffer_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .exception      (exception),
        .mret_sig       (mret_sig),
        .memwrite       (memwrite),
        .memread        (memread),
        .funct3         (funct3),
        .mem_addr       (mem_addr),
        .mem_data       (mem_data),
        .inst_num       (inst_num),
        .load_phy       (load_phy),
        .commit         (commit),
        .commit_addr    (commit_addr),
        .commit_inst_num(commit_inst_num),
        .fwd_data       (fwd_data),
        .fwd_mask       (load_fwd_mask),
        .load_size      (load_size),
        .load_phy_out   (load_phy_out),
        .inst_num_out   (inst_num_out),
        .load_done      (load_done),
        .order_violation(order_violation),
        .sb_full        (sb_full),
        .drain_we       (drain_we),
        .drain_addr     (drain_addr),
        .drain_data     (drain_data),
        .drain_mask     (drain_mask)
    );

    data_mem #(
        .MEM_WORDS(MEM_WORDS)
    ) data_mem_i (
        .clk  (clk),
        .rst_n(rst_n),
        .we   (drain_we),
        .waddr(drain_addr),
        .wdata(drain_data),
        .wmask(drain_mask),
        .raddr(mem_addr),   // Captured at the load edge
        .rdata(mem_word)
    );

    load_merge load_merge_i (
        .fwd_data (fwd_data),
        .fwd_mask (load_fwd_mask),
        .mem_word (mem_word),
        .load_size(load_size),
        .load_data(load_data)
    );

endmodule

// ==== testbench/lsu_props.sv ====
module lsu_props (
    input logic clk,
    input logic rst_n,
    input logic memwrite,
    input logic memread,
    input logic exception,
    input logic mret_sig,
    input logic load_done,
    input logic sb_full
);

    a_rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(memwrite && memread))
        else $error("memwrite and memread high in the same cycle");

    a_load_done: assert property (@(posedge clk) disable iff (!rst_n)
        memread |=> load_done)
        else $error("load_done did not follow memread");

    a_no_store_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(memwrite && sb_full))
        else $error("Store issued while the store buffer is full");

    // Flush frees every entry
    a_flush_empties: assert property (@(posedge clk) disable iff (!rst_n)
        (exception || mret_sig) |=> !sb_full)
        else $error("sb_full still high after a flush");

endmodule

// ==== testbench/lsu_tb.sv ====
module lsu_tb
    import isa_pkg::*, ooo_pkg::*;
();
    localparam int DEPTH   = 4;
    localparam int N_WORDS = 6;
    localparam int NUM_OPS = 2000;
    localparam int TIMEOUT = 4 * NUM_OPS * 2 + 400;

    typedef struct packed {
        word_t     data;
        cov_t      mask;
        inst_num_t tag;
        phy_reg_t  phy;
        logic      viol;
    } load_exp_t;

    logic      clk, rst_n, exception, mret_sig, memwrite, memread, commit;
    mem_size_t funct3;
    addr_t     mem_addr, commit_addr;
    word_t     mem_data, load_data;
    inst_num_t inst_num, commit_inst_num, inst_num_out;
    phy_reg_t  load_phy, load_phy_out;
    cov_t      load_fwd_mask;
    logic      load_done, order_violation, sb_full;

    integer     seed = 18322;
    int         op_idx;
    inst_num_t  cur_tag;
    logic [7:0] mem_m [N_WORDS*4];   // Byte image of the data memory
    logic       m_valid [DEPTH];
    inst_num_t  m_tag [DEPTH];
    addr_t      m_addr [DEPTH];
    word_t      m_data [DEPTH];
    cov_t       m_cov [DEPTH];
    load_exp_t  exp_q [$];

    lsu_top #(
        .SB_DEPTH(DEPTH)
    ) lsu_top_i (.*);

    bind store_buffer lsu_props lsu_props_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .memwrite (memwrite),
        .memread  (memread),
        .exception(exception),
        .mret_sig (mret_sig),
        .load_done(load_done),
        .sb_full  (sb_full)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "Run stopped at op %0d", op_idx);
    endtask

    initial begin
        #(TIMEOUT);
        stop_run("Watchdog expired before the run finished");
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Fail %s (op %0d): expected %h, actual %h", name, op_idx, exp, act);
        stop_run("Value mismatch");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) report_mismatch(name, exp, act);
    endtask

    task automatic check_mask(input string name, input cov_t exp, input cov_t act);
        if (exp !== act) report_mismatch(name, 32'(exp), 32'(act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) report_mismatch(name, 32'(exp), 32'(act));
    endtask

    task automatic check_tag(input string name, input inst_num_t exp, input inst_num_t act);
        if (exp !== act) report_mismatch(name, exp, act);
    endtask

    task automatic check_phy(input string name, input phy_reg_t exp, input phy_reg_t act);
        if (exp !== act) report_mismatch(name, 32'(exp), 32'(act));
    endtask

    function automatic cov_t lanes_of(input mem_size_t sz);
        case (sz)
            size_byte: return 4'b0001;
            size_half: return 4'b0011;
            default:   return 4'b1111;
        endcase
    endfunction

    function automatic int find_entry(input addr_t a);
        int k;
        k = -1;
        for (int i = 0; i < DEPTH; i++) begin
            if (m_valid[i] && m_addr[i] == a) k = i;
        end
        return k;
    endfunction

    function automatic logic model_full();
        int cnt;
        cnt = 0;
        for (int i = 0; i < DEPTH; i++) begin
            if (m_valid[i]) cnt++;
        end
        return cnt == DEPTH;
    endfunction

    function automatic load_exp_t predict_load(input addr_t a, input mem_size_t sz,
                                              input inst_num_t tag, input phy_reg_t phy);
        load_exp_t e;
        word_t     w;
        int        k;
        int        kk;
        k = find_entry(a);
        kk = (k < 0) ? 0 : k;
        e.mask = (k >= 0) ? (m_cov[kk] & lanes_of(sz)) : 4'b0000;
        for (int n = 0; n < 4; n++) begin
            w[8*n +: 8] = e.mask[n] ? m_data[kk][8*n +: 8] : mem_m[a + n];
        end
        case (sz)
            size_byte: e.data = {{24{w[7]}}, w[7:0]};
            size_half: e.data = {{16{w[15]}}, w[15:0]};
            default:   e.data = w;
        endcase
        e.tag  = tag;
        e.phy  = phy;
        e.viol = (k >= 0) && (m_tag[kk] > tag);   // Matched store is younger
        return e;
    endfunction

    task automatic check_outputs();
        load_exp_t e;
        if (load_done) begin
            if (exp_q.size() == 0) begin
                stop_run("load_done pulsed while no load was outstanding");
            end else begin
                e = exp_q.pop_front();
                check_word("load_data", e.data, load_data);
                check_mask("load_fwd_mask", e.mask, load_fwd_mask);
                check_tag("inst_num_out", e.tag, inst_num_out);
                check_phy("load_phy_out", e.phy, load_phy_out);
                check_bit("order_violation", e.viol, order_violation);
            end
        end else if (exp_q.size() != 0) begin
            stop_run("load_done missing one cycle after memread");
        end else begin
            check_bit("order_violation idle", 1'b0, order_violation);
        end
        check_bit("sb_full", model_full(), sb_full);
    endtask

    task automatic drive_cycle();
        int        kind;
        int        k;
        int        oldest;
        int        slot;
        addr_t     a;
        mem_size_t sz;
        word_t     d;
        word_t     nd;
        cov_t      sc;
        inst_num_t lt;
        kind = {$random(seed)} % 3;
        a = addr_t'(({$random(seed)} % N_WORDS) * 4);
        case ({$random(seed)} % 3)
            0:       sz = size_byte;
            1:       sz = size_half;
            default: sz = size_word;
        endcase
        d = $random(seed);
        memwrite = 1'b0;
        memread = 1'b0;
        commit = 1'b0;
        exception = 1'b0;
        mret_sig = 1'b0;
        mem_addr = a;
        funct3 = sz;
        mem_data = d;
        commit_addr = '0;
        commit_inst_num = '0;
        oldest = -1;
        slot = -1;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (m_valid[i] && (oldest < 0 || m_tag[i] < m_tag[oldest])) oldest = i;
            if (!m_valid[i]) slot = i;   // Lowest free slot
        end
        if (kind == 1) begin
            lt = cur_tag + 4 - ({$random(seed)} % 8);
            load_phy = phy_reg_t'($random(seed));
            inst_num = lt;
            memread = 1'b1;
            exp_q.push_back(predict_load(a, sz, lt, load_phy));
        end
        if (oldest >= 0 && ({$random(seed)} % 2) == 0) begin
            commit = 1'b1;
            commit_addr = m_addr[oldest];
            commit_inst_num = m_tag[oldest];
        end
        if (({$random(seed)} % 40) == 0) begin
            if ($random(seed) & 1) exception = 1'b1;
            else mret_sig = 1'b1;
        end
        if (kind == 0 && !model_full()) begin
            cur_tag++;
            inst_num = cur_tag;
            memwrite = 1'b1;
        end
        k = memwrite ? find_entry(a) : -1;
        if (commit) begin
            if (k == oldest) k = -1;   // Entry leaving this cycle is not merged
            for (int n = 0; n < 4; n++) begin
                if (m_cov[oldest][n]) mem_m[m_addr[oldest] + n] = m_data[oldest][8*n +: 8];
            end
            m_valid[oldest] = 1'b0;
        end
        if (memwrite) begin
            sc = lanes_of(sz);
            for (int n = 0; n < 4; n++) begin
                if (sc[n]) nd[8*n +: 8] = d[8*n +: 8];
                else if (k >= 0 && m_cov[k][n]) nd[8*n +: 8] = m_data[k][8*n +: 8];
                else nd[8*n +: 8] = 8'h00;
            end
            if (k >= 0) begin
                sc = sc | m_cov[k];
                m_valid[k] = 1'b0;
            end
            m_valid[slot] = 1'b1;
            m_tag[slot] = cur_tag;
            m_addr[slot] = a;
            m_data[slot] = nd;
            m_cov[slot] = sc;
        end
        if (exception || mret_sig) begin
            for (int i = 0; i < DEPTH; i++) m_valid[i] = 1'b0;
        end
    endtask

    initial begin
        rst_n = 1'b0;
        exception = 1'b0;
        mret_sig = 1'b0;
        memwrite = 1'b0;
        memread = 1'b0;
        funct3 = size_word;
        mem_addr = '0;
        mem_data = '0;
        inst_num = '0;
        load_phy = '0;
        commit = 1'b0;
        commit_addr = '0;
        commit_inst_num = '0;
        op_idx = 0;
        cur_tag = 100;
        for (int i = 0; i < N_WORDS * 4; i++) mem_m[i] = 8'h00;
        for (int i = 0; i < DEPTH; i++) m_valid[i] = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_bit("load_done after reset", 1'b0, load_done);
        check_bit("order_violation after reset", 1'b0, order_violation);
        check_bit("sb_full after reset", 1'b0, sb_full);
        check_bit("drain_we after reset", 1'b0, lsu_top_i.store_buffer_i.drain_we);
        for (op_idx = 0; op_idx < NUM_OPS; op_idx++) begin
            @(posedge clk);
            #1;
            check_outputs();
            drive_cycle();
        end
        @(posedge clk);
        #1;
        check_outputs();
        memwrite = 1'b0;
        memread = 1'b0;
        commit = 1'b0;
        exception = 1'b0;
        mret_sig = 1'b0;
        @(posedge clk);
        #1;
        if (exp_q.size() == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            stop_run("Loads still waiting for load_done at the end of the run");
        end
    end

endmodule

// ==== project.f ====
hdl/isa_pkg.sv
hdl/ooo_pkg.sv
hdl/store_buffer.sv
hdl/data_mem.sv
hdl/load_merge.sv
hdl/lsu_top.sv
testbench/lsu_props.sv
testbench/lsu_tb.sv

// ==== Makefile ====
TOP = lsu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log
